// File: verilog/csr_pkg.sv
`default_nettype none

package csr_pkg;

    typedef enum logic [2:0] {
        NONE    = 3'd0,
        CSRRD   = 3'd1,
        CSRWR   = 3'd2,
        CSRXCHG = 3'd3,
        ERTN    = 3'd4,
        EXCP    = 3'd5
    } csr_op_e;

    // csr numbers
    localparam logic [13:0] CSR_CRMD   = 14'h000;
    localparam logic [13:0] CSR_PRMD   = 14'h001;
    localparam logic [13:0] CSR_ECFG   = 14'h004;
    localparam logic [13:0] CSR_ESTAT  = 14'h005;
    localparam logic [13:0] CSR_ERA    = 14'h006;
    localparam logic [13:0] CSR_BADV   = 14'h007;
    localparam logic [13:0] CSR_EENTRY = 14'h00c;
    localparam logic [13:0] CSR_SAVE0  = 14'h030;
    localparam logic [13:0] CSR_SAVE1  = 14'h031;
    localparam logic [13:0] CSR_SAVE2  = 14'h032;
    localparam logic [13:0] CSR_SAVE3  = 14'h033;
    localparam logic [13:0] CSR_TID    = 14'h040;
    localparam logic [13:0] CSR_TCFG   = 14'h041;
    localparam logic [13:0] CSR_TVAL   = 14'h042;
    localparam logic [13:0] CSR_TICLR  = 14'h044;

    localparam logic [5:0] ECODE_INT = 6'h00;
    localparam logic [5:0] ECODE_ADE = 6'h08;
    localparam logic [8:0] ESUB_ADEF = 9'h000; // fetch address error

    localparam int INT_BITS = 13;

    typedef struct packed {
        csr_op_e     op;
        logic [13:0] num;
        logic [31:0] wdata;
        logic [31:0] mask;
        logic [31:0] pc;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] badv;
    } csr_req_t;

    typedef struct packed {
        logic        valid;
        logic        flush;
        logic [31:0] target; // redirect pc
        logic [31:0] rdata;
    } csr_rsp_t;

    typedef struct packed {
        logic        en;
        logic [13:0] num;
        logic [31:0] data;
    } csr_wr_t;

    typedef struct packed {
        logic        enter;
        logic        ertn;
        logic [31:0] pc;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] badv;
    } csr_trap_t;

    // same bit order as the architectural CRMD
    typedef struct packed {
        logic [1:0] datm;
        logic [1:0] datf;
        logic       pg;
        logic       da;
        logic       ie;
        logic [1:0] plv;
    } crmd_t;

endpackage

`default_nettype wire

// File: verilog/csr_timer.sv
`timescale 1ns/1ps
`default_nettype none

module csr_timer import csr_pkg::*; #(
    parameter int TIMER_N = 20
) (
    input  wire logic    clk,
    input  wire logic    rstn,
    input  wire csr_wr_t wr,
    output logic         ti,
    output logic [31:0]  tcfg_val,
    output logic [31:0]  tval_val
);

    logic [TIMER_N-1:0] tcfg;  // en, periodic, initial value
    logic [TIMER_N-1:0] tval;
    logic               en;
    logic               periodic;
    logic               ti_clr;

    assign en       = tcfg[0];
    assign periodic = tcfg[1];
    assign ti_clr   = wr.en && wr.num == CSR_TICLR && wr.data[0];

    assign tcfg_val = 32'(tcfg);
    assign tval_val = 32'(tval);

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg <= '0;
            tval <= '0;
            ti   <= 1'b0;
        end
        else
        begin
            if (wr.en && wr.num == CSR_TCFG)
                tcfg <= wr.data[TIMER_N-1:0];

            if (ti_clr)
                ti <= 1'b0;
            else if (en && tval == TIMER_N'(1))
                ti <= 1'b1; // counting 1 -> 0

            if (tval == '0 && (periodic || (en && !ti)))
                tval <= {tcfg[TIMER_N-1:2], 2'b00};
            else if (en && tval != '0)
                tval <= tval - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module csr_regfile import csr_pkg::*; #(
    parameter int TIMER_N = 20
) (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic [13:0] num,
    input  wire csr_wr_t     wr,
    input  wire csr_trap_t   trap,
    input  wire logic [7:0]  hw_irq,
    input  wire logic        ipi,
    input  wire logic        ti,
    input  wire logic [31:0] tcfg_val,
    input  wire logic [31:0] tval_val,
    output logic [31:0]      rdata_old,
    output logic [31:0]      era,
    output logic [31:0]      eentry,
    output logic             int_req,
    output crmd_t            crmd
);

    localparam crmd_t CRMD_RESET = '{datm: 2'b00, datf: 2'b00, pg: 1'b0,
                                     da: 1'b1, ie: 1'b0, plv: 2'b00};
    localparam logic [31:0] TIMER_MASK = 32'((64'd1 << TIMER_N) - 64'd1);

    crmd_t                crmd_q;
    logic [1:0]           prmd_pplv;
    logic                 prmd_pie;
    logic [INT_BITS-1:0]  ecfg_lie;
    logic [1:0]           estat_is;   // software interrupt bits
    logic [5:0]           estat_ecode;
    logic [8:0]           estat_esub;
    logic [31:0]          era_q;
    logic [31:0]          badv_q;
    logic [31:6]          eentry_q;
    logic [31:0]          save [4];
    logic [31:0]          tid_q;
    logic [INT_BITS-1:0]  pending;
    logic [31:0]          estat_val;

    assign pending   = {ipi, ti, 1'b0, hw_irq, estat_is};
    assign int_req   = crmd_q.ie && |(pending & ecfg_lie);
    assign estat_val = {1'b0, estat_esub, estat_ecode, 3'b0, pending};

    assign crmd   = crmd_q;
    assign era    = era_q;
    assign eentry = {eentry_q, 6'b0};

    always_comb
    begin
        case (num)
            CSR_CRMD:   rdata_old = {23'b0, crmd_q};
            CSR_PRMD:   rdata_old = {29'b0, prmd_pie, prmd_pplv};
            CSR_ECFG:   rdata_old = {19'b0, ecfg_lie};
            CSR_ESTAT:  rdata_old = estat_val;
            CSR_ERA:    rdata_old = era_q;
            CSR_BADV:   rdata_old = badv_q;
            CSR_EENTRY: rdata_old = {eentry_q, 6'b0};
            CSR_SAVE0:  rdata_old = save[0];
            CSR_SAVE1:  rdata_old = save[1];
            CSR_SAVE2:  rdata_old = save[2];
            CSR_SAVE3:  rdata_old = save[3];
            CSR_TID:    rdata_old = tid_q;
            CSR_TCFG:   rdata_old = tcfg_val & TIMER_MASK;
            CSR_TVAL:   rdata_old = tval_val & TIMER_MASK;
            default:    rdata_old = '0; // TICLR and unknown numbers
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd_q      <= CRMD_RESET;
            prmd_pplv   <= '0;
            prmd_pie    <= 1'b0;
            ecfg_lie    <= '0;
            estat_is    <= '0;
            estat_ecode <= '0;
            estat_esub  <= '0;
            era_q       <= '0;
            badv_q      <= '0;
            eentry_q    <= '0;
            save        <= '{default: '0};
            tid_q       <= '0;
        end
        else if (trap.enter)
        begin
            prmd_pplv   <= crmd_q.plv;
            prmd_pie    <= crmd_q.ie;
            crmd_q.plv  <= 2'b00;
            crmd_q.ie   <= 1'b0;
            era_q       <= trap.pc;
            estat_ecode <= trap.ecode;
            estat_esub  <= trap.esubcode;
            badv_q      <= trap.badv;
        end
        else if (trap.ertn)
        begin
            crmd_q.plv <= prmd_pplv;
            crmd_q.ie  <= prmd_pie;
        end
        else if (wr.en)
        begin
            case (wr.num)
                CSR_CRMD:
                begin
                    crmd_q.plv  <= wr.data[1:0];
                    crmd_q.ie   <= wr.data[2];
                    crmd_q.datf <= wr.data[6:5];
                    crmd_q.datm <= wr.data[8:7];
                    if (wr.data[3] ^ wr.data[4]) // da/pg must stay one-hot
                    begin
                        crmd_q.da <= wr.data[3];
                        crmd_q.pg <= wr.data[4];
                    end
                end
                CSR_PRMD:
                begin
                    prmd_pplv <= wr.data[1:0];
                    prmd_pie  <= wr.data[2];
                end
                CSR_ECFG:   ecfg_lie <= {wr.data[12:11], 1'b0, wr.data[9:0]};
                CSR_ESTAT:  estat_is <= wr.data[1:0];
                CSR_ERA:    era_q <= wr.data;
                CSR_BADV:   badv_q <= wr.data;
                CSR_EENTRY: eentry_q <= wr.data[31:6];
                CSR_SAVE0:  save[0] <= wr.data;
                CSR_SAVE1:  save[1] <= wr.data;
                CSR_SAVE2:  save[2] <= wr.data;
                CSR_SAVE3:  save[3] <= wr.data;
                CSR_TID:    tid_q <= wr.data;
                default: ; // timer csrs live in csr_timer
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/csr_issue.sv
`timescale 1ns/1ps
`default_nettype none

module csr_issue import csr_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire csr_req_t    req,
    input  wire logic        stall,
    input  wire logic        int_req,
    input  wire logic [31:0] rdata_old,
    input  wire logic [31:0] era,
    input  wire logic [31:0] eentry,
    output csr_rsp_t         rsp,
    output csr_wr_t          wr,
    output csr_trap_t        trap
);

    logic        commit_busy;
    logic        take_int;
    logic        accept;
    logic [31:0] xmask;
    logic [31:0] merged;
    csr_rsp_t    rsp_d;
    csr_wr_t     wr_d;
    csr_trap_t   trap_d;

    // state is stale until the registered commit lands
    assign commit_busy = wr.en | trap.enter | trap.ertn;
    assign take_int    = int_req && !commit_busy;
    assign accept      = (req.op != NONE) && !stall && !take_int;

    assign xmask  = (req.op == CSRXCHG) ? req.mask : '1;
    assign merged = (rdata_old & ~xmask) | (req.wdata & xmask);

    always_comb
    begin
        rsp_d  = '0;
        wr_d   = '0;
        trap_d = '0;

        wr_d.num       = req.num;
        wr_d.data      = merged;
        trap_d.pc      = req.pc;
        trap_d.badv    = req.badv;
        trap_d.ecode   = req.ecode;
        trap_d.esubcode = req.esubcode;
        if (req.ecode == ECODE_ADE && req.esubcode == ESUB_ADEF)
            trap_d.badv = req.pc; // pc is the bad address on a fetch fault

        if (take_int)
        begin
            rsp_d.valid     = 1'b1;
            rsp_d.flush     = 1'b1;
            rsp_d.target    = {eentry[31:6], 6'b0};
            trap_d.enter    = 1'b1;
            trap_d.ecode    = ECODE_INT;
            trap_d.esubcode = '0;
            trap_d.badv     = req.badv;
        end
        else if (accept)
        begin
            rsp_d.valid = 1'b1;
            case (req.op)
                CSRRD:
                    rsp_d.rdata = rdata_old;
                CSRWR, CSRXCHG:
                begin
                    rsp_d.rdata  = rdata_old;
                    rsp_d.flush  = 1'b1;
                    rsp_d.target = req.pc + 32'd4;
                    wr_d.en      = 1'b1;
                end
                ERTN:
                begin
                    rsp_d.flush  = 1'b1;
                    rsp_d.target = era;
                    trap_d.ertn  = 1'b1;
                end
                EXCP:
                begin
                    rsp_d.flush  = 1'b1;
                    rsp_d.target = {eentry[31:6], 6'b0};
                    trap_d.enter = 1'b1;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            rsp.valid  <= 1'b0;
            rsp.flush  <= 1'b0;
            wr.en      <= 1'b0;
            trap.enter <= 1'b0;
            trap.ertn  <= 1'b0;
        end
        else
        begin
            rsp  <= rsp_d;
            wr   <= wr_d;
            trap <= trap_d;
        end
    end

endmodule

`default_nettype wire

// File: verilog/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit import csr_pkg::*; #(
    parameter int TIMER_N = 20
) (
    input  wire logic       clk,
    input  wire logic       rstn,
    input  wire csr_req_t   req,
    input  wire logic       stall,
    input  wire logic [7:0] hw_irq,
    input  wire logic       ipi,
    output csr_rsp_t        rsp,
    output crmd_t           crmd
);

    logic        int_req;
    logic [31:0] rdata_old;
    logic [31:0] era;
    logic [31:0] eentry;
    csr_wr_t     wr;
    csr_trap_t   trap;
    logic        ti;
    logic [31:0] tcfg_val;
    logic [31:0] tval_val;

    csr_issue issue_i (
        .clk       (clk),
        .rstn      (rstn),
        .req       (req),
        .stall     (stall),
        .int_req   (int_req),
        .rdata_old (rdata_old),
        .era       (era),
        .eentry    (eentry),
        .rsp       (rsp),
        .wr        (wr),
        .trap      (trap)
    );

    csr_regfile #(.TIMER_N(TIMER_N)) regfile_i (
        .clk       (clk),
        .rstn      (rstn),
        .num       (req.num), // old value for the incoming request
        .wr        (wr),
        .trap      (trap),
        .hw_irq    (hw_irq),
        .ipi       (ipi),
        .ti        (ti),
        .tcfg_val  (tcfg_val),
        .tval_val  (tval_val),
        .rdata_old (rdata_old),
        .era       (era),
        .eentry    (eentry),
        .int_req   (int_req),
        .crmd      (crmd)
    );

    csr_timer #(.TIMER_N(TIMER_N)) timer_i (
        .clk      (clk),
        .rstn     (rstn),
        .wr       (wr),
        .ti       (ti),
        .tcfg_val (tcfg_val),
        .tval_val (tval_val)
    );

endmodule

`default_nettype wire

// File: testbench/csr_tb_tasks.svh
`ifndef CSR_TB_TASKS_SVH
`define CSR_TB_TASKS_SVH

function automatic logic [31:0] merge_masked(input logic [31:0] old, input logic [31:0] wdata,
                                             input logic [31:0] mask);
    logic [31:0] merged;
    for (int i = 0; i < 32; i++)
        merged[i] = mask[i] ? wdata[i] : old[i];
    return merged;
endfunction

// ecode at 21:16, esubcode at 30:22, pending lines at 12:0
function automatic logic [31:0] estat_word(input logic [8:0] esub, input logic [5:0] ecode,
                                           input logic [12:0] pending);
    return (32'(esub) << 22) | (32'(ecode) << 16) | 32'(pending);
endfunction

function automatic csr_req_t make_req(input csr_op_e op, input logic [13:0] num,
                                      input logic [31:0] wdata, input logic [31:0] mask);
    csr_req_t r;
    r       = '0;
    r.op    = op;
    r.num   = num;
    r.wdata = wdata;
    r.mask  = mask;
    r.pc    = $urandom & 32'hffff_fffc; // word aligned
    return r;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    check_count++;
    assert (actual === expected)
    else
    begin
        error_count++;
        $display("Error: %s expected %h actual %h", name, expected, actual);
    end
endtask

// runs from one falling edge to the one that shows the response
task automatic send(input string name, input csr_req_t r, output csr_rsp_t got);
    int waited;
    waited = 0;
    req = r;
    @(negedge clk);
    while (!rsp.valid && waited < REQ_TIMEOUT)
    begin
        @(negedge clk);
        waited++;
    end
    if (!rsp.valid)
    begin
        error_count++;
        $display("%s got no response within %0d cycles", name, REQ_TIMEOUT);
    end
    got = rsp;
    req = '0;
endtask

task automatic check_redirect(input string name, input csr_rsp_t got,
                              input logic [31:0] target);
    check_value({name, " valid"}, 32'd1, 32'(got.valid));
    check_value({name, " flush"}, 32'd1, 32'(got.flush));
    check_value({name, " target"}, target, got.target);
endtask

task automatic read_check(input string name, input logic [13:0] num,
                          input logic [31:0] expected);
    csr_rsp_t got;
    send(name, make_req(CSRRD, num, '0, '0), got);
    check_value({name, " flush"}, 32'd0, 32'(got.flush));
    check_value(name, expected, got.rdata);
endtask

// csr state lands one edge after the response
task automatic write_check(input string name, input logic [13:0] num, input logic [31:0] data,
                           input logic [31:0] old);
    csr_req_t r;
    csr_rsp_t got;
    r = make_req(CSRWR, num, data, '0);
    send(name, r, got);
    check_value({name, " old"}, old, got.rdata);
    check_redirect(name, got, r.pc + 32'd4);
    @(negedge clk);
endtask

`endif

// File: testbench/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb import csr_pkg::*; ();

    localparam int TIMER_N         = 20;
    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 8;
    localparam int REQ_TIMEOUT     = 8;
    localparam int TIMER_INIT      = 16; // multiple of 4
    localparam int NUM_REQS        = 48;
    localparam int TEST_CYCLES     = NUM_REQS * (REQ_TIMEOUT + 2);
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 4 * (TIMER_INIT + 4);

    logic       clk;
    logic       rstn;
    csr_req_t   req;
    logic       stall;
    logic [7:0] hw_irq;
    logic       ipi;
    csr_rsp_t   rsp;
    crmd_t      crmd;
    int         error_count;
    int         check_count;

    `include "csr_tb_tasks.svh"

    csr_unit #(.TIMER_N(TIMER_N)) dut_i (
        .clk    (clk),
        .rstn   (rstn),
        .req    (req),
        .stall  (stall),
        .hw_irq (hw_irq),
        .ipi    (ipi),
        .rsp    (rsp),
        .crmd   (crmd)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial
    begin
        csr_req_t    r;
        csr_rsp_t    got;
        logic [31:0] save_val [4];
        logic [31:0] tid_val;
        logic [31:0] era_val;
        logic [31:0] eentry_val;
        logic [31:0] wdata;
        logic [31:0] mask;
        int          waited;
        int          seen;

        void'($urandom(32'h077b_4732));
        error_count = 0;
        check_count = 0;
        rstn   = 1'b0;
        req    = '0;
        stall  = 1'b0;
        hw_irq = '0;
        ipi    = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rstn = 1'b1;
        check_value("reset rsp valid", 32'd0, 32'(rsp.valid));
        check_value("reset crmd", 32'h008, 32'(crmd)); // da only

        for (int i = 0; i < 4; i++)
        begin
            save_val[i] = $urandom;
            write_check("save write", CSR_SAVE0 + 14'(i), save_val[i], 32'd0);
        end
        tid_val = $urandom;
        era_val = $urandom;
        write_check("tid write", CSR_TID, tid_val, 32'd0);
        write_check("era write", CSR_ERA, era_val, 32'd0);
        for (int i = 0; i < 4; i++)
            read_check("save read", CSR_SAVE0 + 14'(i), save_val[i]);
        read_check("tid read", CSR_TID, tid_val);
        read_check("era read", CSR_ERA, era_val);
        read_check("unknown csr read", 14'h3ff, 32'd0);
        read_check("ticlr read", CSR_TICLR, 32'd0);

        wdata = $urandom;
        mask  = $urandom;
        r = make_req(CSRXCHG, CSR_SAVE1, wdata, mask);
        send("xchg", r, got);
        check_value("xchg old", save_val[1], got.rdata);
        check_redirect("xchg", got, r.pc + 32'd4);
        @(negedge clk);
        save_val[1] = merge_masked(save_val[1], wdata, mask);
        read_check("xchg merged", CSR_SAVE1, save_val[1]);

        // exception entry from plv 3 with interrupts on
        eentry_val = $urandom & 32'hffff_ffc0;
        write_check("eentry write", CSR_EENTRY, eentry_val, 32'd0);
        write_check("crmd write", CSR_CRMD, 32'h00f, 32'h008);
        r = make_req(EXCP, '0, '0, '0);
        r.ecode = 6'($urandom_range(1, 63));
        if (r.ecode == ECODE_ADE)
            r.ecode = 6'h0a;
        r.esubcode = 9'($urandom);
        r.badv     = $urandom;
        send("excp", r, got);
        check_redirect("excp", got, eentry_val);
        @(negedge clk);
        era_val = r.pc;
        read_check("excp era", CSR_ERA, era_val);
        read_check("excp estat", CSR_ESTAT, estat_word(r.esubcode, r.ecode, 13'h0));
        read_check("excp badv", CSR_BADV, r.badv);
        read_check("excp prmd", CSR_PRMD, 32'h007);
        check_value("excp crmd", 32'h008, 32'(crmd));

        send("ertn", make_req(ERTN, '0, '0, '0), got);
        check_redirect("ertn", got, era_val);
        @(negedge clk);
        check_value("ertn crmd", 32'h00f, 32'(crmd));

        r = make_req(EXCP, '0, '0, '0);
        r.ecode    = ECODE_ADE;
        r.esubcode = ESUB_ADEF;
        r.badv     = $urandom;
        send("adef", r, got);
        check_redirect("adef", got, eentry_val);
        @(negedge clk);
        era_val = r.pc;
        read_check("adef badv", CSR_BADV, r.pc); // fetch fault reports the pc
        send("adef ertn", make_req(ERTN, '0, '0, '0), got);
        check_redirect("adef ertn", got, era_val);
        @(negedge clk);

        stall = 1'b1;
        req   = make_req(CSRRD, CSR_SAVE2, '0, '0);
        repeat (3)
        begin
            @(negedge clk);
            check_value("stall held", 32'd0, 32'(rsp.valid));
        end
        stall = 1'b0;
        @(negedge clk);
        req = '0;
        check_value("stall release valid", 32'd1, 32'(rsp.valid));
        check_value("stall release data", save_val[2], rsp.rdata);

        write_check("ecfg write", CSR_ECFG, 32'h800, 32'd0); // timer line only
        write_check("crmd ie", CSR_CRMD, 32'h00c, 32'h00f);
        write_check("tcfg write", CSR_TCFG, 32'(TIMER_INIT) | 32'd1, 32'd0);
        waited = 1;
        while (!rsp.valid && waited < TIMER_INIT + 4)
        begin
            @(negedge clk);
            waited++;
        end
        got = rsp;
        check_redirect("timer irq", got, eentry_val);
        @(negedge clk);
        era_val = 32'd0; // idle bus carries pc 0
        read_check("timer estat", CSR_ESTAT, estat_word(9'h0, ECODE_INT, 13'h800));

        write_check("tcfg stop", CSR_TCFG, 32'd0, 32'(TIMER_INIT) | 32'd1);
        write_check("ticlr write", CSR_TICLR, 32'd1, 32'd0);
        read_check("ticlr estat", CSR_ESTAT, estat_word(9'h0, ECODE_INT, 13'h0));
        send("timer ertn", make_req(ERTN, '0, '0, '0), got);
        check_redirect("timer ertn", got, era_val);
        seen = 0;
        repeat (TIMER_INIT + 4)
        begin
            @(negedge clk);
            seen += int'(rsp.valid);
        end
        check_value("no irq after ticlr", 32'd0, 32'(seen));
        check_value("crmd after timer", 32'h00c, 32'(crmd));

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+testbench
verilog/csr_pkg.sv
verilog/csr_timer.sv
verilog/csr_regfile.sv
verilog/csr_issue.sv
verilog/csr_unit.sv
testbench/csr_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run, then search the output for the pass line
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module csr_unit_tb \
    && ./obj_dir/Vcsr_unit_tb | tee /dev/stderr | grep -q "Testbench passed" \
    && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }
